// File: Makefile
# Verilator build and run of the HBA subsystem testbench.
VERILATOR ?= verilator
TOP       ?= hba_system_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= No errors

.PHONY: sim clean

# Passes only when the pass line shows up in the simulation output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
src/hba_bus_pkg.sv
src/hba_periph_pkg.sv
src/hba_master.sv
src/hba_basicio.sv
src/hba_gpio.sv
src/hba_system.sv
tests/tb_clock.sv
tests/hba_system_props.sv
tests/hba_system_tb.sv

// File: src/hba_basicio.sv
/*
 * Basic I/O slave on the HBA bus. Drives the LEDs, reads the buttons and
 * raises an interrupt on enabled button rising edges.
 */
`timescale 1ns/1ps

module hba_basicio #(
    parameter hba_bus_pkg::hba_periph_t PERIPH_ADDR = hba_bus_pkg::SLOT_BASICIO
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hba_select,
    input  logic                   hba_rnw,
    input  hba_bus_pkg::hba_addr_t hba_abus,
    input  hba_bus_pkg::hba_data_t hba_dbus,
    output hba_bus_pkg::hba_data_t hba_dbus_slave,     // Zero unless acking a read.
    output logic                   hba_xferack_slave,  // One-cycle ack.
    output logic                   slave_interrupt,
    output hba_bus_pkg::hba_data_t basicio_led,
    input  hba_bus_pkg::hba_data_t basicio_button
);

    hba_bus_pkg::hba_periph_t slot;
    hba_bus_pkg::hba_reg_t    reg_offset;
    logic                     hit;          // Selected at our slot.
    logic                     done;         // Ack already given this select.
    logic                     wr_en;
    hba_bus_pkg::hba_data_t   led_q;
    hba_bus_pkg::hba_data_t   int_en;
    hba_bus_pkg::hba_data_t   int_stat;
    hba_bus_pkg::hba_data_t   button_meta;  // First sync stage.
    hba_bus_pkg::hba_data_t   button_sync;  // Second sync stage.
    hba_bus_pkg::hba_data_t   button_prev;
    hba_bus_pkg::hba_data_t   button_rise;
    hba_bus_pkg::hba_data_t   stat_clr;
    hba_bus_pkg::hba_data_t   rd_data;

    assign slot       = hba_abus[hba_bus_pkg::ADDR_WIDTH-1 -: hba_bus_pkg::PERIPH_ADDR_WIDTH];
    assign reg_offset = hba_abus[hba_bus_pkg::REG_ADDR_WIDTH-1:0];
    assign hit        = hba_select && (slot == PERIPH_ADDR);
    assign wr_en      = hit && !done && (hba_rnw == hba_bus_pkg::RNW_WRITE);

    assign button_rise = button_sync & ~button_prev;
    // Write-one-to-clear mask for the status register.
    assign stat_clr = (wr_en && reg_offset == hba_periph_pkg::BASICIO_INT_STAT) ? hba_dbus : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            hba_xferack_slave <= 1'b0;
            done              <= 1'b0;
            led_q             <= '0;
            int_en            <= '0;
            int_stat          <= '0;
            button_meta       <= '0;
            button_sync       <= '0;
            button_prev       <= '0;
        end else begin
            hba_xferack_slave <= hit && !done;  // Once per select.
            done              <= hit;
            button_meta       <= basicio_button;
            button_sync       <= button_meta;
            button_prev       <= button_sync;
            int_stat          <= (int_stat & ~stat_clr) | button_rise;  // New edge wins.
            if (wr_en && reg_offset == hba_periph_pkg::BASICIO_LED) led_q <= hba_dbus;
            if (wr_en && reg_offset == hba_periph_pkg::BASICIO_INT_EN) int_en <= hba_dbus;
        end
    end

    always_comb begin
        case (reg_offset)
            hba_periph_pkg::BASICIO_LED:      rd_data = led_q;
            hba_periph_pkg::BASICIO_BUTTON:   rd_data = button_sync;
            hba_periph_pkg::BASICIO_INT_EN:   rd_data = int_en;
            hba_periph_pkg::BASICIO_INT_STAT: rd_data = int_stat;
            default:                          rd_data = '0;  // Unmapped offset.
        endcase
    end

    assign hba_dbus_slave = (hba_xferack_slave && hba_rnw == hba_bus_pkg::RNW_READ) ? rd_data : '0;

    assign slave_interrupt = |(int_stat & int_en);
    assign basicio_led     = led_q;

endmodule

// File: src/hba_bus_pkg.sv
/*
 * HBA bus definitions shared by the master, the slaves and the top level.
 * Widths, address fields, default slot numbers and the rnw encoding.
 */
package hba_bus_pkg;

    localparam int DBUS_WIDTH        = 8;  // Data bus width.
    localparam int PERIPH_ADDR_WIDTH = 4;  // Slot bits on top of the address.
    localparam int REG_ADDR_WIDTH    = 8;  // Register bits below the slot.
    localparam int ADDR_WIDTH        = PERIPH_ADDR_WIDTH + REG_ADDR_WIDTH;

    typedef logic [DBUS_WIDTH-1:0]        hba_data_t;    // Bus and register word.
    typedef logic [PERIPH_ADDR_WIDTH-1:0] hba_periph_t;  // Slot number.
    typedef logic [REG_ADDR_WIDTH-1:0]    hba_reg_t;     // Offset inside a slot.
    typedef logic [ADDR_WIDTH-1:0]        hba_addr_t;    // Slot and offset together.

    // Default slot map.
    localparam hba_periph_t SLOT_BASICIO = 4'd1;
    localparam hba_periph_t SLOT_GPIO    = 4'd2;

    // Transfer direction as seen on hba_rnw.
    localparam logic RNW_READ  = 1'b1;
    localparam logic RNW_WRITE = 1'b0;

endpackage

// File: src/hba_gpio.sv
/*
 * GPIO slave on the HBA bus. Four bidirectional pins with output enable,
 * a two-flop input synchronizer and an interrupt on any input change.
 */
`timescale 1ns/1ps

module hba_gpio #(
    parameter hba_bus_pkg::hba_periph_t PERIPH_ADDR = hba_bus_pkg::SLOT_GPIO
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  hba_select,
    input  logic                                  hba_rnw,
    input  hba_bus_pkg::hba_addr_t                hba_abus,
    input  hba_bus_pkg::hba_data_t                hba_dbus,
    output hba_bus_pkg::hba_data_t                hba_dbus_slave,     // Zero unless reading.
    output logic                                  hba_xferack_slave,  // One-cycle ack.
    output logic                                  slave_interrupt,
    output logic [hba_periph_pkg::GPIO_WIDTH-1:0] gpio_out_en,   // Pad direction.
    output logic [hba_periph_pkg::GPIO_WIDTH-1:0] gpio_out_sig,  // Pad output value.
    input  logic [hba_periph_pkg::GPIO_WIDTH-1:0] gpio_in_sig    // Raw pad input.
);

    hba_bus_pkg::hba_periph_t                slot;
    hba_bus_pkg::hba_reg_t                   reg_offset;
    logic                                    hit;
    logic                                    done;
    logic                                    wr_en;
    logic [hba_periph_pkg::GPIO_WIDTH-1:0]   out_en;
    logic [hba_periph_pkg::GPIO_WIDTH-1:0]   out_sig;
    logic [hba_periph_pkg::GPIO_WIDTH-1:0]   int_en;
    logic [hba_periph_pkg::GPIO_WIDTH-1:0]   int_stat;
    logic [hba_periph_pkg::GPIO_WIDTH-1:0]   in_meta;
    logic [hba_periph_pkg::GPIO_WIDTH-1:0]   in_sync;
    logic [hba_periph_pkg::GPIO_WIDTH-1:0]   in_prev;
    logic [hba_periph_pkg::GPIO_WIDTH-1:0]   in_change;
    logic [hba_periph_pkg::GPIO_WIDTH-1:0]   stat_clr;
    hba_bus_pkg::hba_data_t                  rd_data;

    assign slot       = hba_abus[hba_bus_pkg::ADDR_WIDTH-1 -: hba_bus_pkg::PERIPH_ADDR_WIDTH];
    assign reg_offset = hba_abus[hba_bus_pkg::REG_ADDR_WIDTH-1:0];
    assign hit        = hba_select && (slot == PERIPH_ADDR);
    assign wr_en      = hit && !done && (hba_rnw == hba_bus_pkg::RNW_WRITE);

    // Both edges count as a change.
    assign in_change = in_sync ^ in_prev;
    assign stat_clr  = (wr_en && reg_offset == hba_periph_pkg::GPIO_INT_STAT)
                     ? hba_dbus[hba_periph_pkg::GPIO_WIDTH-1:0] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            hba_xferack_slave <= 1'b0;
            done              <= 1'b0;
            out_en            <= '0;  // All pins inputs.
            out_sig           <= '0;
            int_en            <= '0;
            int_stat          <= '0;
            in_meta           <= '0;
            in_sync           <= '0;
            in_prev           <= '0;
        end else begin
            hba_xferack_slave <= hit && !done;
            done              <= hit;         // Held while select stays up.
            in_meta           <= gpio_in_sig;
            in_sync           <= in_meta;
            in_prev           <= in_sync;
            int_stat          <= (int_stat & ~stat_clr) | in_change;
            if (wr_en) begin
                case (reg_offset)
                    hba_periph_pkg::GPIO_OUT_EN:  out_en  <= hba_dbus[hba_periph_pkg::GPIO_WIDTH-1:0];
                    hba_periph_pkg::GPIO_OUT_SIG: out_sig <= hba_dbus[hba_periph_pkg::GPIO_WIDTH-1:0];
                    hba_periph_pkg::GPIO_INT_EN:  int_en  <= hba_dbus[hba_periph_pkg::GPIO_WIDTH-1:0];
                    default: ;  // Read-only or unmapped.
                endcase
            end
        end
    end

    // Narrow registers read back zero-extended.
    always_comb begin
        case (reg_offset)
            hba_periph_pkg::GPIO_OUT_EN:   rd_data = hba_bus_pkg::hba_data_t'(out_en);
            hba_periph_pkg::GPIO_OUT_SIG:  rd_data = hba_bus_pkg::hba_data_t'(out_sig);
            hba_periph_pkg::GPIO_IN:       rd_data = hba_bus_pkg::hba_data_t'(in_sync);
            hba_periph_pkg::GPIO_INT_EN:   rd_data = hba_bus_pkg::hba_data_t'(int_en);
            hba_periph_pkg::GPIO_INT_STAT: rd_data = hba_bus_pkg::hba_data_t'(int_stat);
            default:                       rd_data = '0;
        endcase
    end

    assign hba_dbus_slave = (hba_xferack_slave && hba_rnw == hba_bus_pkg::RNW_READ) ? rd_data : '0;

    assign slave_interrupt = |(int_stat & int_en);
    assign gpio_out_en     = out_en;
    assign gpio_out_sig    = out_sig;

endmodule

// File: src/hba_master.sv
/*
 * Single HBA bus master. Takes one host request at a time, runs one bus
 * transfer and returns a one-cycle response, with an error on ack timeout.
 */
`timescale 1ns/1ps

module hba_master #(
    parameter int TIMEOUT_CYCLES = 16  // Select cycles before giving up.
) (
    input  logic                   clk,
    input  logic                   reset,
    // Host request port.
    input  logic                   req_valid,
    input  logic                   req_rnw,
    input  hba_bus_pkg::hba_addr_t req_addr,
    input  hba_bus_pkg::hba_data_t req_wdata,
    output logic                   req_ready,
    output logic                   resp_valid,
    output logic                   resp_err,
    output hba_bus_pkg::hba_data_t resp_rdata,
    // HBA bus.
    output logic                   hba_select,
    output logic                   hba_rnw,
    output hba_bus_pkg::hba_addr_t hba_abus,
    output hba_bus_pkg::hba_data_t hba_dbus,
    input  logic                   hba_xferack,
    input  hba_bus_pkg::hba_data_t hba_dbus_s
);

    localparam int TIMER_WIDTH = $clog2(TIMEOUT_CYCLES + 1);

    typedef enum logic [1:0] {
        IDLE,  // Waiting for a host request.
        XFER,  // Select held until ack or timeout.
        RESP   // Response pulse to the host.
    } state_t;

    state_t                 state;
    logic [TIMER_WIDTH-1:0] timer;    // Cycles spent in XFER.
    logic                   err_q;    // Last transfer timed out.
    logic                   rnw_q;    // Registered request.
    hba_bus_pkg::hba_addr_t addr_q;
    hba_bus_pkg::hba_data_t wdata_q;
    hba_bus_pkg::hba_data_t rdata_q;  // Captured read data.
    logic                   accept;
    logic                   timeout;

    assign accept  = req_valid && req_ready;
    // Last select cycle with no slave answering.
    assign timeout = (timer == TIMER_WIDTH'(TIMEOUT_CYCLES - 1)) && !hba_xferack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            timer <= '0;
            err_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    timer <= '0;
                    if (accept) begin
                        state <= XFER;
                        err_q <= 1'b0;  // Fresh request, fresh status.
                    end
                end
                XFER: begin
                    timer <= timer + 1'b1;
                    if (hba_xferack) begin
                        state <= RESP;
                    end else if (timeout) begin
                        state <= RESP;
                        err_q <= 1'b1;  // No slave at this slot.
                    end
                end
                default: state <= IDLE;  // RESP lasts one cycle.
            endcase
        end
    end

    // Request and response holding.
    always_ff @(posedge clk) begin
        if (accept) begin
            rnw_q   <= req_rnw;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
        if (state == XFER) begin
            rdata_q <= hba_xferack ? hba_dbus_s : '0;  // Stays zero on timeout.
        end
    end

    assign req_ready  = (state == IDLE);
    assign resp_valid = (state == RESP);
    assign resp_err   = err_q;
    assign resp_rdata = rdata_q;

    // Bus is driven only during the transfer, zero otherwise.
    assign hba_select = (state == XFER);
    assign hba_rnw    = hba_select && rnw_q;
    assign hba_abus   = hba_select ? addr_q : '0;
    assign hba_dbus   = hba_select ? wdata_q : '0;

endmodule

// File: src/hba_periph_pkg.sv
/*
 * Register maps of the basic I/O and GPIO slaves.
 * Offsets are the lower address bits inside each slot.
 */
package hba_periph_pkg;

    // Basic I/O slave.
    localparam hba_bus_pkg::hba_reg_t BASICIO_LED      = 8'd0;  // LED value, R/W.
    localparam hba_bus_pkg::hba_reg_t BASICIO_BUTTON   = 8'd1;  // Synced buttons, RO.
    localparam hba_bus_pkg::hba_reg_t BASICIO_INT_EN   = 8'd2;  // Per-button enable.
    localparam hba_bus_pkg::hba_reg_t BASICIO_INT_STAT = 8'd3;  // Write 1 to clear.

    // GPIO slave.
    localparam hba_bus_pkg::hba_reg_t GPIO_OUT_EN   = 8'd0;  // 1 drives the pin.
    localparam hba_bus_pkg::hba_reg_t GPIO_OUT_SIG  = 8'd1;  // Driven value.
    localparam hba_bus_pkg::hba_reg_t GPIO_IN       = 8'd2;  // Synced pin state, RO.
    localparam hba_bus_pkg::hba_reg_t GPIO_INT_EN   = 8'd3;  // Per-pin enable.
    localparam hba_bus_pkg::hba_reg_t GPIO_INT_STAT = 8'd4;  // Write 1 to clear.

    // Number of GPIO pins.
    localparam int GPIO_WIDTH = 4;

endpackage

// File: src/hba_system.sv
/*
 * Peripheral subsystem top level. One host-driven master and two slaves
 * on a shared HBA bus, with slave data, acks and interrupts ORed together.
 */
`timescale 1ns/1ps

module hba_system #(
    parameter int                       TIMEOUT_CYCLES = 16,
    parameter hba_bus_pkg::hba_periph_t BASICIO_ADDR   = hba_bus_pkg::SLOT_BASICIO,
    parameter hba_bus_pkg::hba_periph_t GPIO_ADDR      = hba_bus_pkg::SLOT_GPIO
) (
    input  logic                                  clk,
    input  logic                                  reset,
    // Host port.
    input  logic                                  req_valid,
    input  logic                                  req_rnw,
    input  hba_bus_pkg::hba_addr_t                req_addr,
    input  hba_bus_pkg::hba_data_t                req_wdata,
    output logic                                  req_ready,
    output logic                                  resp_valid,
    output logic                                  resp_err,
    output hba_bus_pkg::hba_data_t                resp_rdata,
    output logic                                  intr,          // Any enabled slave interrupt.
    // Basic I/O pins.
    output hba_bus_pkg::hba_data_t                basicio_led,
    input  hba_bus_pkg::hba_data_t                basicio_button,
    // GPIO pins.
    output logic [hba_periph_pkg::GPIO_WIDTH-1:0] gpio_out_en,
    output logic [hba_periph_pkg::GPIO_WIDTH-1:0] gpio_out_sig,
    input  logic [hba_periph_pkg::GPIO_WIDTH-1:0] gpio_in_sig
);

    // Master to slaves.
    logic                   hba_select;
    logic                   hba_rnw;
    hba_bus_pkg::hba_addr_t hba_abus;
    hba_bus_pkg::hba_data_t hba_dbus;
    // Slaves to master, after the OR.
    logic                   hba_xferack;
    hba_bus_pkg::hba_data_t hba_dbus_s;
    // Per-slave returns.
    hba_bus_pkg::hba_data_t hba_dbus_slave_basicio;
    hba_bus_pkg::hba_data_t hba_dbus_slave_gpio;
    logic                   hba_xferack_basicio;
    logic                   hba_xferack_gpio;
    logic                   interrupt_basicio;
    logic                   interrupt_gpio;

    hba_master #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) hba_master_inst (
        .clk(clk),               .reset(reset),
        .req_valid(req_valid),   .req_rnw(req_rnw),
        .req_addr(req_addr),     .req_wdata(req_wdata),
        .req_ready(req_ready),   .resp_valid(resp_valid),
        .resp_err(resp_err),     .resp_rdata(resp_rdata),
        .hba_select(hba_select), .hba_rnw(hba_rnw),
        .hba_abus(hba_abus),     .hba_dbus(hba_dbus),
        .hba_xferack(hba_xferack), .hba_dbus_s(hba_dbus_s)
    );

    hba_basicio #(
        .PERIPH_ADDR(BASICIO_ADDR)
    ) hba_basicio_inst (
        .clk(clk),               .reset(reset),
        .hba_select(hba_select), .hba_rnw(hba_rnw),
        .hba_abus(hba_abus),     .hba_dbus(hba_dbus),
        .hba_dbus_slave(hba_dbus_slave_basicio),
        .hba_xferack_slave(hba_xferack_basicio),
        .slave_interrupt(interrupt_basicio),
        .basicio_led(basicio_led), .basicio_button(basicio_button)
    );

    hba_gpio #(
        .PERIPH_ADDR(GPIO_ADDR)
    ) hba_gpio_inst (
        .clk(clk),               .reset(reset),
        .hba_select(hba_select), .hba_rnw(hba_rnw),
        .hba_abus(hba_abus),     .hba_dbus(hba_dbus),
        .hba_dbus_slave(hba_dbus_slave_gpio),
        .hba_xferack_slave(hba_xferack_gpio),
        .slave_interrupt(interrupt_gpio),
        .gpio_out_en(gpio_out_en), .gpio_out_sig(gpio_out_sig), .gpio_in_sig(gpio_in_sig)
    );

    // Idle slaves drive zeros, so a plain OR merges them.
    assign hba_dbus_s  = hba_dbus_slave_basicio | hba_dbus_slave_gpio;
    assign hba_xferack = hba_xferack_basicio | hba_xferack_gpio;
    assign intr        = interrupt_basicio | interrupt_gpio;

endmodule

// File: tests/hba_system_props.sv
/*
 * Concurrent bus and timing checks for hba_system, bound into the top
 * level. Host latency, ack shape, idle slave data and reset state.
 */
`timescale 1ns/1ps

module hba_system_props #(
    parameter int                       TIMEOUT_CYCLES = 16,
    parameter hba_bus_pkg::hba_periph_t BASICIO_ADDR   = hba_bus_pkg::SLOT_BASICIO,
    parameter hba_bus_pkg::hba_periph_t GPIO_ADDR      = hba_bus_pkg::SLOT_GPIO
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   req_valid,
    input logic                   req_ready,
    input hba_bus_pkg::hba_addr_t req_addr,
    input logic                   resp_valid,
    input logic                   resp_err,
    input hba_bus_pkg::hba_data_t resp_rdata,
    input logic                   hba_select,
    input logic                   hba_xferack,
    input hba_bus_pkg::hba_data_t hba_dbus_s,
    input logic                   intr
);

    int                       fail_count = 0;  // Failed assertions so far.
    logic                     accept;
    logic                     mapped;
    hba_bus_pkg::hba_periph_t req_slot;

    assign accept   = req_valid && req_ready;
    assign req_slot = req_addr[hba_bus_pkg::ADDR_WIDTH-1 -: hba_bus_pkg::PERIPH_ADDR_WIDTH];
    assign mapped   = (req_slot == BASICIO_ADDR) || (req_slot == GPIO_ADDR);

    // Mapped slot answers in exactly three cycles.
    mapped_latency: assert property (@(posedge clk) disable iff (reset)
        accept && mapped |-> ##3 (resp_valid && !resp_err))
        else begin
            $error("mapped access latency is not 3 cycles");
            fail_count++;
        end

    timeout_latency: assert property (@(posedge clk) disable iff (reset)
        accept && !mapped |-> ##(TIMEOUT_CYCLES + 1) (resp_valid && resp_err && resp_rdata == '0))
        else begin
            $error("unmapped access did not time out on schedule");
            fail_count++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        hba_xferack |=> !hba_xferack)
        else begin
            $error("xferack high for two cycles");
            fail_count++;
        end

    idle_data_zero: assert property (@(posedge clk) disable iff (reset)
        !hba_xferack |-> (hba_dbus_s == '0))
        else begin
            $error("slave data nonzero without ack");
            fail_count++;
        end

    // Ready stays low from acceptance through the response pulse.
    busy_after_accept: assert property (@(posedge clk) disable iff (reset)
        accept |=> !req_ready)
        else begin
            $error("req_ready high right after acceptance");
            fail_count++;
        end

    busy_until_resp: assert property (@(posedge clk) disable iff (reset)
        !req_ready && !resp_valid |=> !req_ready)
        else begin
            $error("req_ready rose before the response");
            fail_count++;
        end

    reset_state: assert property (@(posedge clk)
        reset |=> (!hba_select && !resp_valid && !intr && req_ready))
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

endmodule

bind hba_system hba_system_props #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES), .BASICIO_ADDR(BASICIO_ADDR), .GPIO_ADDR(GPIO_ADDR)
) props_inst (
    .clk(clk),               .reset(reset),
    .req_valid(req_valid),   .req_ready(req_ready),   .req_addr(req_addr),
    .resp_valid(resp_valid), .resp_err(resp_err),     .resp_rdata(resp_rdata),
    .hba_select(hba_select), .hba_xferack(hba_xferack), .hba_dbus_s(hba_dbus_s),
    .intr(intr)
);

// File: tests/hba_system_tb.sv
/*
 * Testbench for the HBA peripheral subsystem. Runs register, input,
 * interrupt and timeout tests through the host port of hba_system.
 */
`timescale 1ns/1ps

module hba_system_tb;

    localparam int TIMEOUT_CYCLES = 16;
    localparam int CYCLE_LIMIT    = 4000;  // About 60 transfers of up to 20 cycles plus settling.
    localparam int RESP_LIMIT     = TIMEOUT_CYCLES + 4;

    typedef logic [hba_periph_pkg::GPIO_WIDTH-1:0] gpio_t;
    typedef hba_bus_pkg::hba_data_t                data_t;

    logic                   clk;
    logic                   reset;
    logic                   req_valid;
    logic                   req_rnw;
    hba_bus_pkg::hba_addr_t req_addr;
    data_t                  req_wdata;
    logic                   req_ready;
    logic                   resp_valid;
    logic                   resp_err;
    data_t                  resp_rdata;
    logic                   intr;
    data_t                  basicio_led;
    data_t                  basicio_button;
    gpio_t                  gpio_out_en;
    gpio_t                  gpio_out_sig;
    gpio_t                  gpio_in_sig;

    logic [31:0] lfsr_state = 32'hb9b9;
    int          error_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;
    int          start_errors = 0;  // Error total when the current test began.
    int          cycle_count = 0;
    int          latency;           // Edges from acceptance to response.
    int          idx;
    data_t       rdata;
    data_t       wdata;
    logic        err;

    tb_clock clock_gen (.clk(clk), .reset(reset));

    hba_system #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) dut0 (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_rnw(req_rnw), .req_addr(req_addr), .req_wdata(req_wdata),
        .req_ready(req_ready), .resp_valid(resp_valid), .resp_err(resp_err),
        .resp_rdata(resp_rdata), .intr(intr),
        .basicio_led(basicio_led), .basicio_button(basicio_button),
        .gpio_out_en(gpio_out_en), .gpio_out_sig(gpio_out_sig), .gpio_in_sig(gpio_in_sig)
    );

    // Fibonacci LFSR with taps 32 22 2 1, stepped once per bit.
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic int total_errors();
        return error_count + dut0.props_inst.fail_count;  // Own checks plus bound assertions.
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;  // Drive and sample point.
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: expected 0x%02h, got 0x%02h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic bus_access(input logic rnw, input hba_bus_pkg::hba_periph_t slot,
                              input hba_bus_pkg::hba_reg_t offset, input data_t data);
        while (!req_ready) next_cycle();
        req_valid = 1'b1;
        req_rnw   = rnw;
        req_addr  = {slot, offset};
        req_wdata = data;
        next_cycle();  // Taken at this edge.
        req_valid = 1'b0;
        latency   = 1;
        while (!resp_valid) begin
            if (latency > RESP_LIMIT) begin
                $display("No response from the DUT within %0d cycles of a request.", RESP_LIMIT);
                error_count++;
                break;
            end
            next_cycle();
            latency++;
        end
        rdata = resp_rdata;
        err   = resp_err;
    endtask

    task automatic read_check(input hba_bus_pkg::hba_periph_t slot,
                              input hba_bus_pkg::hba_reg_t offset, input data_t expected,
                              input string reg_name);
        bus_access(hba_bus_pkg::RNW_READ, slot, offset, '0);
        check_value({"resp_rdata ", reg_name}, expected, rdata);
        check_value({"resp_err ", reg_name}, 8'h00, data_t'(err));
    endtask

    task automatic write_reg(input hba_bus_pkg::hba_periph_t slot,
                             input hba_bus_pkg::hba_reg_t offset, input data_t data);
        bus_access(hba_bus_pkg::RNW_WRITE, slot, offset, data);
        check_value("resp_err on write", 8'h00, data_t'(err));
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (total_errors() != start_errors) failed_tests++;
        $display("Test %-10s %s", name, (total_errors() == start_errors) ? "passed" : "FAILED");
        start_errors = total_errors();
    endtask

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("Run stopped after %0d cycles because a test hung.", CYCLE_LIMIT);
        $display("Errors found");
        $finish;
    end

    initial begin
        req_valid      = 1'b0;
        req_rnw        = 1'b0;
        req_addr       = '0;
        req_wdata      = '0;
        basicio_button = '0;
        gpio_in_sig    = '0;
        next_cycle();
        wait (!reset);
        next_cycle();  // First edge out of reset.

        // Writable registers read back and reach the pins; GPIO keeps 4 bits.
        for (int i = 0; i < 6; i++) begin
            wdata = data_t'(rand_bits(8));
            write_reg(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_LED, wdata);
            read_check(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_LED, wdata, "LED");
            check_value("basicio_led", wdata, basicio_led);
            wdata = data_t'(rand_bits(8));
            write_reg(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_OUT_EN, wdata);
            read_check(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_OUT_EN,
                       data_t'(gpio_t'(wdata)), "GPIO_OUT_EN");
            check_value("gpio_out_en", data_t'(gpio_t'(wdata)), data_t'(gpio_out_en));
            wdata = data_t'(rand_bits(8));
            write_reg(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_OUT_SIG, wdata);
            read_check(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_OUT_SIG,
                       data_t'(gpio_t'(wdata)), "GPIO_OUT_SIG");
            check_value("gpio_out_sig", data_t'(gpio_t'(wdata)), data_t'(gpio_out_sig));
        end
        finish_test("registers");

        for (int i = 0; i < 4; i++) begin
            basicio_button = data_t'(rand_bits(8));
            gpio_in_sig    = gpio_t'(rand_bits(hba_periph_pkg::GPIO_WIDTH));
            repeat (3) next_cycle();  // Through both sync flops.
            read_check(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_BUTTON,
                       basicio_button, "BUTTON");
            read_check(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_IN,
                       data_t'(gpio_in_sig), "GPIO_IN");
        end
        read_check(hba_bus_pkg::SLOT_BASICIO, 8'h10, 8'h00, "basicio unmapped");
        read_check(hba_bus_pkg::SLOT_GPIO, 8'h20, 8'h00, "gpio unmapped");
        finish_test("inputs");

        basicio_button = '0;
        gpio_in_sig    = '0;
        repeat (4) next_cycle();  // Last edges land in status first.
        write_reg(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_INT_STAT, 8'hff);
        write_reg(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_INT_STAT, 8'h0f);
        read_check(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_INT_STAT, 8'h00,
                   "BASICIO_INT_STAT");
        read_check(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_INT_STAT, 8'h00, "GPIO_INT_STAT");
        idx = int'(rand_bits(3));
        write_reg(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_INT_EN, data_t'(1 << idx));
        basicio_button = data_t'(1 << idx);  // Rising edge on the enabled button.
        repeat (4) next_cycle();
        check_value("intr", 8'h01, data_t'(intr));
        read_check(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_INT_STAT,
                   data_t'(1 << idx), "BASICIO_INT_STAT");
        write_reg(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_INT_STAT, data_t'(1 << idx));
        check_value("intr", 8'h00, data_t'(intr));
        basicio_button = '0;  // Falling edge sets no status.
        repeat (4) next_cycle();
        read_check(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_INT_STAT, 8'h00,
                   "BASICIO_INT_STAT");
        write_reg(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_INT_EN, 8'h00);
        idx = int'(rand_bits(2));
        write_reg(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_INT_EN, data_t'(1 << idx));
        gpio_in_sig = gpio_t'(1 << idx);
        repeat (4) next_cycle();
        check_value("intr", 8'h01, data_t'(intr));
        read_check(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_INT_STAT,
                   data_t'(1 << idx), "GPIO_INT_STAT");
        write_reg(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_INT_STAT, data_t'(1 << idx));
        check_value("intr", 8'h00, data_t'(intr));
        write_reg(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_INT_EN, 8'h00);
        // Status still records every edge with the enables off.
        wdata          = data_t'(rand_bits(8)) | 8'h01;
        basicio_button = wdata;         // All rising from zero.
        gpio_in_sig    = ~gpio_in_sig;  // Every pin changes.
        repeat (4) next_cycle();
        check_value("intr", 8'h00, data_t'(intr));
        read_check(hba_bus_pkg::SLOT_BASICIO, hba_periph_pkg::BASICIO_INT_STAT, wdata,
                   "BASICIO_INT_STAT");
        read_check(hba_bus_pkg::SLOT_GPIO, hba_periph_pkg::GPIO_INT_STAT, 8'h0f, "GPIO_INT_STAT");
        finish_test("interrupts");

        bus_access(hba_bus_pkg::RNW_READ, hba_bus_pkg::hba_periph_t'(5), 8'h00, 8'h00);
        check_value("resp_err", 8'h01, data_t'(err));
        check_value("resp_rdata", 8'h00, rdata);
        check_value("latency", data_t'(TIMEOUT_CYCLES + 1), data_t'(latency));
        bus_access(hba_bus_pkg::RNW_WRITE, hba_bus_pkg::hba_periph_t'(5), 8'h03, 8'h5a);
        check_value("resp_err", 8'h01, data_t'(err));
        finish_test("timeout");

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, total_errors());
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
/*
 * Testbench clock and reset source. 40 ns clock, synchronous reset held
 * high over the first two rising edges.
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 20;  // 40 ns period.

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;  // Released just after the second edge.
    end

    always #HALF_PERIOD clk = ~clk;

endmodule
